//--- icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Cache geometry
`define ICACHE_LINES                8
`define PREFETCH_STREAM_BUFFER_SIZE 4
`define ICACHE_DEPTH                (`ICACHE_LINES + `PREFETCH_STREAM_BUFFER_SIZE)
// Line index width that covers ICACHE_DEPTH
`define ICACHE_INDEX_BITS           4

// Memory transactions where tag zero means none
`define NUM_MEM_TAGS                16
`define MEM_TAG_BITS                4

// Address split and block size
`define I_ADDR_BITS                 32
`define ITAG_BITS                   13
`define BLOCK_OFFSET_BITS           3
`define MEM_BLOCK_BITS              64

// Nonzero start value of the eviction LFSR
`define LFSR_SEED                   4'b1011

`endif

//--- icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // Instruction address with the upper bits always zero
    typedef struct packed {
        logic [`I_ADDR_BITS-`ITAG_BITS-`BLOCK_OFFSET_BITS-1:0] zeros;
        logic [`ITAG_BITS-1:0]                                  tag;
        logic [`BLOCK_OFFSET_BITS-1:0]                          block_offset;
    } i_addr_t;

    typedef struct packed {
        logic    valid;
        i_addr_t addr;
    } i_addr_packet_t;

    typedef logic [`MEM_TAG_BITS-1:0]   mem_tag_t;
    typedef logic [`MEM_BLOCK_BITS-1:0] mem_block_t;

    typedef struct packed {
        logic       valid;
        mem_block_t data;
    } cache_data_t;

    typedef struct packed {
        logic                  valid;
        logic [`ITAG_BITS-1:0] tag;
        mem_block_t            data;
    } i_cache_line_t;

    // One outstanding memory transaction
    typedef struct packed {
        logic                  valid;
        mem_tag_t              mem_tag;
        logic [`ITAG_BITS-1:0] i_tag;
    } mshr_entry_t;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_DATA,
        REQ_INST
    } requester_e;

    typedef struct packed {
        logic       valid;
        i_addr_t    addr;
        requester_e requester;
    } mem_req_t;

endpackage

//--- icache_store.sv
`include "icache_macros.svh"

module icache_store
    import icache_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_reset,

    // Fetch reads with entry 0 the older one
    input  i_addr_packet_t [1:0] i_read_addrs,
    output cache_data_t [1:0]    o_cache_outs,

    // Prefetcher snoop
    input  i_addr_packet_t       i_snoop_addr,
    output logic                 o_snoop_found,
    output logic                 o_full,

    // Fill from memory
    input  i_addr_packet_t       i_write_addr,
    input  mem_block_t           i_write_data
);

    i_cache_line_t [`ICACHE_DEPTH-1:0]  lines;
    logic [`ICACHE_DEPTH-1:0]           valid_bits;
    logic [`ICACHE_INDEX_BITS-1:0]      lfsr;
    logic [`ICACHE_INDEX_BITS-1:0]      free_idx;
    logic [`ICACHE_INDEX_BITS-1:0]      evict_idx;
    logic [`ICACHE_INDEX_BITS-1:0]      write_idx;

    // Tag match on both read ports
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            o_cache_outs[j] = '0;
            for (int i = 0; i < `ICACHE_DEPTH; i++) begin
                if (i_read_addrs[j].valid && lines[i].valid &&
                    lines[i].tag == i_read_addrs[j].addr.tag) begin
                    o_cache_outs[j].valid = 1'b1;
                    o_cache_outs[j].data  = lines[i].data;
                end
            end
        end
    end

    always_comb begin
        o_snoop_found = 1'b0;
        for (int i = 0; i < `ICACHE_DEPTH; i++) begin
            valid_bits[i] = lines[i].valid;
            if (i_snoop_addr.valid && lines[i].valid &&
                lines[i].tag == i_snoop_addr.addr.tag) begin
                o_snoop_found = 1'b1;
            end
        end
    end

    assign o_full = &valid_bits;

    // Downward scan so the lowest free line wins
    always_comb begin
        free_idx = '0;
        for (int i = `ICACHE_DEPTH - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                free_idx = `ICACHE_INDEX_BITS'(i);
            end
        end
    end

    // Free running LFSR with taps x^4 + x^3 + 1
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= {lfsr[`ICACHE_INDEX_BITS-2:0],
                     lfsr[`ICACHE_INDEX_BITS-1] ^ lfsr[`ICACHE_INDEX_BITS-2]};
        end
    end

    assign evict_idx = `ICACHE_INDEX_BITS'(lfsr % `ICACHE_DEPTH);
    assign write_idx = o_full ? evict_idx : free_idx;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            lines <= '0;
        end else if (i_write_addr.valid) begin
            lines[write_idx].valid <= 1'b1;
            lines[write_idx].tag   <= i_write_addr.addr.tag;
            lines[write_idx].data  <= i_write_data;
        end
    end

endmodule

//--- i_prefetcher.sv
module i_prefetcher
    import icache_pkg::*;
(
    input  logic           i_clock,
    input  logic           i_reset,
    input  i_addr_packet_t i_miss_addr,
    input  logic           i_cache_full,
    input  logic           i_req_accepted,
    output i_addr_packet_t o_snoop_addr
);

    i_addr_packet_t last_miss;
    i_addr_packet_t next_last_miss;
    i_addr_t        stream_ptr;
    i_addr_t        next_stream_ptr;
    logic           new_miss;

    // A miss to a block other than the last requested one
    assign new_miss = i_miss_addr.valid &&
                      (!last_miss.valid || i_miss_addr.addr.tag != last_miss.addr.tag);

    always_comb begin
        o_snoop_addr    = '0;
        next_last_miss  = last_miss;
        next_stream_ptr = stream_ptr;
        if (new_miss) begin
            // Demand request that becomes the stream base once taken
            o_snoop_addr = i_miss_addr;
            if (i_req_accepted) begin
                next_last_miss  = i_miss_addr;
                next_stream_ptr = i_miss_addr.addr;
            end
        end else if (!i_cache_full && last_miss.valid) begin
            // Next block in sequence
            o_snoop_addr.valid    = 1'b1;
            o_snoop_addr.addr     = stream_ptr;
            o_snoop_addr.addr.tag = stream_ptr.tag + 1'b1;
            if (i_req_accepted) begin
                next_stream_ptr = o_snoop_addr.addr;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_miss  <= '0;
            stream_ptr <= '0;
        end else begin
            last_miss  <= next_last_miss;
            stream_ptr <= next_stream_ptr;
        end
    end

endmodule

//--- i_mshr.sv
`include "icache_macros.svh"

module i_mshr
    import icache_pkg::*;
(
    input  logic           i_clock,
    input  logic           i_reset,

    // Duplicate check for the prefetcher
    input  i_addr_t        i_snoop_addr,
    output logic           o_snoop_found,

    // Pushed when memory takes an instruction request
    input  mshr_entry_t    i_new_entry,

    // In-order return from memory
    input  mem_tag_t       i_mem_data_tag,
    output i_addr_packet_t o_fill_addr
);

    mshr_entry_t [`NUM_MEM_TAGS-1:0] entries;
    logic [`MEM_TAG_BITS-1:0]        head;
    logic [`MEM_TAG_BITS-1:0]        tail;
    logic                            pop;

    always_comb begin
        o_snoop_found = 1'b0;
        for (int i = 0; i < `NUM_MEM_TAGS; i++) begin
            if (entries[i].valid && entries[i].i_tag == i_snoop_addr.tag) begin
                o_snoop_found = 1'b1;
            end
        end
    end

    // Returns come back in order, so only the head can match
    assign pop = (i_mem_data_tag != '0) && entries[head].valid &&
                 (i_mem_data_tag == entries[head].mem_tag);

    always_comb begin
        o_fill_addr = '0;
        if (pop) begin
            o_fill_addr.valid    = 1'b1;
            o_fill_addr.addr.tag = entries[head].i_tag;
        end
    end

    // Push after pop so a full queue can turn over in one cycle
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            head    <= '0;
            tail    <= '0;
            entries <= '0;
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head                <= head + 1'b1;
            end
            if (i_new_entry.valid) begin
                entries[tail] <= i_new_entry;
                tail          <= tail + 1'b1;
            end
        end
    end

endmodule

//--- mem_arbiter.sv
module mem_arbiter
    import icache_pkg::*;
(
    // Data side load port
    input  mem_req_t i_dreq,
    // Instruction side after the duplicate filter
    input  mem_req_t i_ireq,

    // Shared memory bus
    input  mem_tag_t i_mem_tag,
    output mem_req_t o_mem_req,

    // Acceptance back to the winner
    output mem_tag_t o_dmem_tag,
    output logic     o_iaccepted
);

    // Data port has fixed priority
    always_comb begin
        o_mem_req   = '0;
        o_dmem_tag  = '0;
        o_iaccepted = 1'b0;

        if (i_dreq.valid) begin
            o_mem_req           = i_dreq;
            o_mem_req.requester = REQ_DATA;
            // Nonzero only in the cycle memory takes it
            o_dmem_tag          = i_mem_tag;
        end else if (i_ireq.valid) begin
            o_mem_req           = i_ireq;
            o_mem_req.requester = REQ_INST;
            o_iaccepted         = (i_mem_tag != '0);
        end
    end

endmodule

//--- icache_subsystem.sv
module icache_subsystem
    import icache_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_reset,

    // Two-wide fetch with entry 0 the older one
    input  i_addr_packet_t [1:0] i_read_addrs,
    output cache_data_t [1:0]    o_cache_outs,

    // Data side load port
    input  mem_req_t             i_dreq,
    output mem_tag_t             o_dmem_tag,

    // Memory
    output mem_req_t             o_mem_req,
    input  mem_tag_t             i_mem_tag,
    input  mem_block_t           i_mem_data,
    input  mem_tag_t             i_mem_data_tag
);

    i_addr_packet_t oldest_miss;
    i_addr_packet_t snoop_addr;
    i_addr_packet_t fill_addr;
    logic           cache_full;
    logic           found_cache;
    logic           found_mshr;
    logic           iaccepted;
    mem_req_t       ireq;
    mshr_entry_t    new_entry;

    icache_store icache_store_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_read_addrs  (i_read_addrs),
        .o_cache_outs  (o_cache_outs),
        .i_snoop_addr  (snoop_addr),
        .o_snoop_found (found_cache),
        .o_full        (cache_full),
        .i_write_addr  (fill_addr),
        .i_write_data  (i_mem_data)
    );

    i_prefetcher i_prefetcher_i (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_miss_addr    (oldest_miss),
        .i_cache_full   (cache_full),
        .i_req_accepted (iaccepted),
        .o_snoop_addr   (snoop_addr)
    );

    i_mshr i_mshr_i (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_snoop_addr   (snoop_addr.addr),
        .o_snoop_found  (found_mshr),
        .i_new_entry    (new_entry),
        .i_mem_data_tag (i_mem_data_tag),
        .o_fill_addr    (fill_addr)
    );

    mem_arbiter mem_arbiter_i (
        .i_dreq      (i_dreq),
        .i_ireq      (ireq),
        .i_mem_tag   (i_mem_tag),
        .o_mem_req   (o_mem_req),
        .o_dmem_tag  (o_dmem_tag),
        .o_iaccepted (iaccepted)
    );

    // Oldest miss goes to the prefetcher
    always_comb begin
        oldest_miss = '0;
        if (i_read_addrs[0].valid && !o_cache_outs[0].valid) begin
            oldest_miss = i_read_addrs[0];
        end else if (i_read_addrs[1].valid && !o_cache_outs[1].valid) begin
            oldest_miss = i_read_addrs[1];
        end
    end

    // Drop blocks already resident or in flight
    always_comb begin
        ireq           = '0;
        ireq.valid     = snoop_addr.valid && !found_cache && !found_mshr;
        ireq.addr      = snoop_addr.addr;
        ireq.requester = REQ_INST;
    end

    always_comb begin
        new_entry         = '0;
        new_entry.valid   = iaccepted;
        new_entry.mem_tag = i_mem_tag;
        new_entry.i_tag   = ireq.addr.tag;
    end

endmodule

//--- tb_icache_subsystem.sv
`include "icache_macros.svh"

module tb_icache_subsystem
    import icache_pkg::*;
();

    // One accepted memory transaction
    typedef struct packed {
        mem_tag_t              tag;
        logic [`ITAG_BITS-1:0] itag;
        logic                  inst;
        logic [31:0]           due;
    } mem_txn_t;

    typedef struct packed {
        logic                  valid;
        logic [`ITAG_BITS-1:0] tag;
    } tag_slot_t;

    logic                  clock;
    logic                  reset;
    logic                  reset_q = 1'b0;
    i_addr_packet_t [1:0]  i_read_addrs;
    cache_data_t [1:0]     o_cache_outs;
    mem_req_t              i_dreq;
    mem_tag_t              o_dmem_tag;
    mem_req_t              o_mem_req;
    mem_tag_t              i_mem_tag = '0;
    mem_block_t            i_mem_data = '0;
    mem_tag_t              i_mem_data_tag = '0;

    // Memory model state
    integer                seed = 24;
    int                    cycle = 0;
    mem_txn_t              mem_q[$];
    mem_txn_t              ret_item = '0;
    logic                  ret_active = 1'b0;
    mem_tag_t              next_tag = 4'd1;

    // Scoreboard with one bit per block tag
    logic [(1 << `ITAG_BITS)-1:0] outstanding = '0;
    logic [(1 << `ITAG_BITS)-1:0] resident = '0;
    int                    returned_cnt = 0;
    logic                  in_window;
    tag_slot_t             last_demand = '0;
    logic [`ITAG_BITS-1:0] stream_next = '0;

    // Expected instruction request
    logic                  miss_valid;
    logic [`ITAG_BITS-1:0] miss_tag;
    logic                  new_miss;
    logic                  exp_ivalid;
    logic [`ITAG_BITS-1:0] exp_tag;

    icache_subsystem icache_subsystem_i (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_read_addrs   (i_read_addrs),
        .o_cache_outs   (o_cache_outs),
        .i_dreq         (i_dreq),
        .o_dmem_tag     (o_dmem_tag),
        .o_mem_req      (o_mem_req),
        .i_mem_tag      (i_mem_tag),
        .i_mem_data     (i_mem_data),
        .i_mem_data_tag (i_mem_data_tag)
    );

    function automatic mem_block_t block_data(input logic [`ITAG_BITS-1:0] tag);
        return {4{{3'b000, tag}}} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    function automatic i_addr_packet_t fetch_packet(input logic valid,
                                                    input logic [`ITAG_BITS-1:0] tag,
                                                    input logic [2:0] offset);
        i_addr_packet_t pkt;
        pkt                   = '0;
        pkt.valid             = valid;
        pkt.addr.tag          = tag;
        pkt.addr.block_offset = offset;
        return pkt;
    endfunction

    function automatic mem_req_t data_request(input logic [`ITAG_BITS-1:0] tag);
        mem_req_t req;
        req          = '0;
        req.valid    = 1'b1;
        req.addr.tag = tag;
        return req;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic wait_hit(input int port);
        do begin
            @(posedge clock);
        end while (!o_cache_outs[port].valid);
    endtask

    task automatic wait_data_accept();
        do begin
            @(posedge clock);
        end while (o_dmem_tag == '0);
        i_dreq <= '0;
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    assign in_window = returned_cnt < `ICACHE_DEPTH;

    // Oldest miss and the prefetcher's next offer
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = '0;
        if (i_read_addrs[0].valid && !resident[i_read_addrs[0].addr.tag]) begin
            miss_valid = 1'b1;
            miss_tag   = i_read_addrs[0].addr.tag;
        end else if (i_read_addrs[1].valid && !resident[i_read_addrs[1].addr.tag]) begin
            miss_valid = 1'b1;
            miss_tag   = i_read_addrs[1].addr.tag;
        end
        new_miss   = miss_valid && (!last_demand.valid || miss_tag != last_demand.tag);
        exp_tag    = new_miss ? miss_tag : stream_next;
        exp_ivalid = (new_miss || last_demand.valid) && !outstanding[exp_tag] &&
                     !resident[exp_tag];
    end

    // In-order memory with random accept stalls and return delays
    always @(posedge clock) begin
        mem_txn_t item;
        reset_q <= reset;
        cycle = cycle + 1;
        if (reset) begin
            i_mem_tag      <= '0;
            i_mem_data_tag <= '0;
        end else begin
            if (o_mem_req.valid && i_mem_tag != '0) begin
                item.tag  = i_mem_tag;
                item.itag = o_mem_req.addr.tag;
                item.inst = !i_dreq.valid;
                item.due  = cycle + 2 + ($random(seed) & 3);
                mem_q.push_back(item);
                if (item.inst) begin
                    outstanding[item.itag] <= 1'b1;
                    stream_next            <= item.itag + 1'b1;
                    if (new_miss) begin
                        last_demand <= {1'b1, miss_tag};
                    end
                end
                next_tag = (next_tag == mem_tag_t'(`NUM_MEM_TAGS - 1)) ? 4'd1 : next_tag + 1'b1;
            end
            if (ret_active && ret_item.inst) begin
                outstanding[ret_item.itag] <= 1'b0;
                resident[ret_item.itag]    <= 1'b1;
                returned_cnt               <= returned_cnt + 1;
            end
            ret_active = 1'b0;
            if (mem_q.size() > 0 && mem_q[0].due <= cycle) begin
                ret_item       = mem_q.pop_front();
                ret_active     = 1'b1;
                i_mem_data_tag <= ret_item.tag;
                i_mem_data     <= block_data(ret_item.itag);
            end else begin
                i_mem_data_tag <= '0;
            end
            i_mem_tag <= (mem_q.size() < 4 && ($random(seed) & 3) != 0) ? next_tag : '0;
        end
    end

    assert property (@(posedge clock) reset_q |-> (!o_mem_req.valid && o_dmem_tag == '0))
        else stop_on_error($sformatf("error: o_mem_req.valid = %h o_dmem_tag = %h, expected 0",
                                     $sampled(o_mem_req.valid), $sampled(o_dmem_tag)));

    assert property (@(posedge clock) disable iff (reset)
        returned_cnt == 0 |-> (!o_cache_outs[0].valid && !o_cache_outs[1].valid))
        else stop_on_error("a fetch hit the cache before any block had returned");

    for (genvar p = 0; p < 2; p++) begin : g_port
        assert property (@(posedge clock) disable iff (reset)
            o_cache_outs[p].valid |-> (i_read_addrs[p].valid &&
                o_cache_outs[p].data == block_data(i_read_addrs[p].addr.tag)))
            else stop_on_error($sformatf("error: o_cache_outs[%0d].data = %h, expected %h", p,
                $sampled(o_cache_outs[p].data), block_data($sampled(i_read_addrs[p].addr.tag))));

        assert property (@(posedge clock) disable iff (reset)
            (in_window && i_read_addrs[p].valid) |->
                (o_cache_outs[p].valid == resident[i_read_addrs[p].addr.tag]))
            else stop_on_error($sformatf("error: o_cache_outs[%0d].valid = %h, expected %h", p,
                $sampled(o_cache_outs[p].valid), $sampled(resident[i_read_addrs[p].addr.tag])));
    end

    // Data port always wins the bus
    assert property (@(posedge clock) disable iff (reset)
        i_dreq.valid |-> (o_mem_req.valid && o_mem_req.requester == REQ_DATA &&
                          o_mem_req.addr == i_dreq.addr && o_dmem_tag == i_mem_tag))
        else stop_on_error($sformatf(
            "error: o_mem_req.requester = %h o_dmem_tag = %h, expected %h %h",
            $sampled(o_mem_req.requester), $sampled(o_dmem_tag), REQ_DATA, $sampled(i_mem_tag)));

    assert property (@(posedge clock) disable iff (reset) !i_dreq.valid |-> o_dmem_tag == '0)
        else stop_on_error($sformatf("error: o_dmem_tag = %h, expected 0", $sampled(o_dmem_tag)));

    assert property (@(posedge clock) disable iff (reset)
        (in_window && !i_dreq.valid) |-> (o_mem_req.valid == exp_ivalid &&
            (!exp_ivalid || (o_mem_req.requester == REQ_INST && o_mem_req.addr.tag == exp_tag))))
        else stop_on_error($sformatf("error: o_mem_req valid %h tag %h, expected valid %h tag %h",
            $sampled(o_mem_req.valid), $sampled(o_mem_req.addr.tag),
            $sampled(exp_ivalid), $sampled(exp_tag)));

    assert property (@(posedge clock) disable iff (reset)
        (o_mem_req.valid && !i_dreq.valid) |-> (o_mem_req.requester == REQ_INST &&
            !outstanding[o_mem_req.addr.tag] && !(in_window && resident[o_mem_req.addr.tag])))
        else stop_on_error($sformatf("error: o_mem_req.addr.tag = %h requester %h repeats a block",
            $sampled(o_mem_req.addr.tag), $sampled(o_mem_req.requester)));

    // Bounded by stimulus steps times the worst memory delay
    initial begin
        int steps;
        int worst_delay;
        int limit;
        steps       = 10;
        worst_delay = 4 * 12;
        limit       = steps * worst_delay + 200;
        repeat (limit) @(posedge clock);
        stop_on_error("timeout: the fetch sequence did not finish in time");
    end

    initial begin
        reset        = 1'b1;
        i_read_addrs = '0;
        i_dreq       = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        repeat (3) @(posedge clock);

        // Data load and a miss on both fetch entries at the same time
        i_read_addrs[0] <= fetch_packet(1'b1, 13'h0200, 3'd2);
        i_read_addrs[1] <= fetch_packet(1'b1, 13'h0400, 3'd6);
        i_dreq          <= data_request(13'h1f00);
        wait_data_accept();

        // Entry 0 goes first and entry 1 follows once entry 0 hits
        wait_hit(0);
        wait_hit(1);

        // Following blocks come from the stream
        i_read_addrs[1] <= '0;
        for (int k = 1; k < 4; k++) begin
            i_read_addrs[0] <= fetch_packet(1'b1, 13'h0200 + 13'(k), 3'd0);
            wait_hit(0);
        end

        i_read_addrs <= '0;
        i_dreq       <= data_request(13'h1f01);
        wait_data_accept();
        repeat (10) @(posedge clock);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
icache_pkg.sv
icache_store.sv
i_prefetcher.sv
i_mshr.sv
mem_arbiter.sv
icache_subsystem.sv
tb_icache_subsystem.sv

//--- Bender.yml
package:
  name: icache_subsystem

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_store.sv
      - i_prefetcher.sv
      - i_mshr.sv
      - mem_arbiter.sv
      - icache_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_icache_subsystem.sv
